// File: common/msr_pkg.sv
// MSR data widths, register address codes, PSR bit positions and CPUID field layout
`default_nettype none

package msr_pkg;

   localparam int WORD_W = 32;
   localparam int PSR_W  = 10;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [PSR_W-1:0]  psr_t;

   // Register address codes
   // 6 and 7 are unused and read as zero
   typedef enum logic [2:0] {
      MSR_PSR    = 3'd0,
      MSR_CPUID  = 3'd1,
      MSR_EPSR   = 3'd2,
      MSR_EPC    = 3'd3,
      MSR_ELSA   = 3'd4,
      MSR_COREID = 3'd5
   } msr_addr_t;

   // PSR field positions
   localparam int PSR_CC   = 0;
   localparam int PSR_RM   = 4;
   localparam int PSR_IRE  = 5;
   localparam int PSR_IMME = 6;
   localparam int PSR_DMME = 7;

   // Cores come out of reset in root mode with everything else off
   localparam psr_t PSR_RESET = psr_t'(1) << PSR_RM;

   // CPUID layout
   localparam int CPUID_VER_W    = 8;
   localparam int CPUID_REV_W    = 10;
   localparam int CPUID_VER_LSB  = 0;
   localparam int CPUID_REV_LSB  = 8;
   localparam int CPUID_IMM_BIT  = 18;
   localparam int CPUID_DMM_BIT  = 19;
   localparam int CPUID_ICA_BIT  = 20;
   localparam int CPUID_DCA_BIT  = 21;
   localparam int CPUID_DBG_BIT  = 22;
   localparam int CPUID_FPU_BIT  = 23;
   localparam int CPUID_IRQC_BIT = 24;
   localparam int CPUID_TSC_BIT  = 25;

endpackage

`default_nettype wire

// File: common/core_pkg.sv
// Cluster description shared by all banks: core count, core index and CPUID contents
`default_nettype none

package core_pkg;

   localparam int NUM_CORES = 4;

   typedef logic [$clog2(NUM_CORES)-1:0] core_id_t;

   localparam logic [msr_pkg::CPUID_VER_W-1:0] CPUID_VER = 8'd1;
   localparam logic [msr_pkg::CPUID_REV_W-1:0] CPUID_REV = 10'd0;

   // Feature flags of blocks outside this cluster
   localparam logic FIMM  = 1'b1;
   localparam logic FDMM  = 1'b1;
   localparam logic FICA  = 1'b0;
   localparam logic FDCA  = 1'b0;
   localparam logic FDBG  = 1'b0;
   localparam logic FFPU  = 1'b0;
   localparam logic FIRQC = 1'b1;
   localparam logic FTSC  = 1'b1;

   localparam msr_pkg::word_t CPUID_WORD =
      (msr_pkg::word_t'(CPUID_VER) << msr_pkg::CPUID_VER_LSB) |
      (msr_pkg::word_t'(CPUID_REV) << msr_pkg::CPUID_REV_LSB) |
      (msr_pkg::word_t'(FIMM)  << msr_pkg::CPUID_IMM_BIT)  |
      (msr_pkg::word_t'(FDMM)  << msr_pkg::CPUID_DMM_BIT)  |
      (msr_pkg::word_t'(FICA)  << msr_pkg::CPUID_ICA_BIT)  |
      (msr_pkg::word_t'(FDCA)  << msr_pkg::CPUID_DCA_BIT)  |
      (msr_pkg::word_t'(FDBG)  << msr_pkg::CPUID_DBG_BIT)  |
      (msr_pkg::word_t'(FFPU)  << msr_pkg::CPUID_FPU_BIT)  |
      (msr_pkg::word_t'(FIRQC) << msr_pkg::CPUID_IRQC_BIT) |
      (msr_pkg::word_t'(FTSC)  << msr_pkg::CPUID_TSC_BIT);

endpackage

`default_nettype wire

// File: common/msr_wr_if.sv
// Per-core write strobes and next values from the access decoder to one MSR bank
`timescale 1ns/1ps
`default_nettype none

interface msr_wr_if;
   import msr_pkg::*;

   // PSR field writes
   logic  cc_we;
   logic  cc_nxt;
   logic  rm_we;
   logic  rm_nxt;
   logic  ire_we;
   logic  ire_nxt;
   logic  imme_we;
   logic  imme_nxt;
   logic  dmme_we;
   logic  dmme_nxt;

   // Exception entry for this core
   logic  exp_ld;

   logic  epsr_we;
   psr_t  epsr_nxt;
   logic  epc_we;
   word_t epc_nxt;
   logic  elsa_we;
   word_t elsa_nxt;

   modport decoder (
      output cc_we, cc_nxt, rm_we, rm_nxt, ire_we, ire_nxt,
             imme_we, imme_nxt, dmme_we, dmme_nxt, exp_ld,
             epsr_we, epsr_nxt, epc_we, epc_nxt, elsa_we, elsa_nxt
   );

   modport bank (
      input cc_we, cc_nxt, rm_we, rm_nxt, ire_we, ire_nxt,
            imme_we, imme_nxt, dmme_we, dmme_nxt, exp_ld,
            epsr_we, epsr_nxt, epc_we, epc_nxt, elsa_we, elsa_nxt
   );

endinterface

`default_nettype wire

// File: common/msr_rd_if.sv
// Bypassed register values of one MSR bank, seen by the read mux and the decoder
`timescale 1ns/1ps
`default_nettype none

interface msr_rd_if;
   import msr_pkg::*;

   psr_t  psr;
   // PSR without the exception load as the source of EPSR on exception entry
   psr_t  psr_nold;
   psr_t  epsr;
   word_t epc;
   word_t elsa;
   word_t cpuid;
   word_t coreid;

   modport bank (
      output psr, psr_nold, epsr, epc, elsa, cpuid, coreid
   );

   modport reader (
      input psr, epsr, epc, elsa, cpuid, coreid
   );

   modport decoder (
      input psr_nold
   );

endinterface

`default_nettype wire

// File: hdl/msr_access_decoder.sv
// Decodes the shared access port and the exception strobe into per-core bank writes
`timescale 1ns/1ps
`default_nettype none

module msr_access_decoder (
   input  core_pkg::core_id_t  acc_core,
   input  msr_pkg::msr_addr_t  acc_addr,
   input  logic                acc_we,
   input  msr_pkg::word_t      acc_wdata,
   input  logic                exp_ent,
   input  core_pkg::core_id_t  exp_core,
   input  msr_pkg::word_t      exp_epc,
   input  msr_pkg::word_t      exp_elsa,
   msr_wr_if.decoder           wr [core_pkg::NUM_CORES],
   msr_rd_if.decoder           rd [core_pkg::NUM_CORES]
);
   import msr_pkg::*;
   import core_pkg::*;

   for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
      logic acc_sel;
      logic exp_sel;
      logic psr_hit;
      logic epsr_hit;
      logic epc_hit;
      logic elsa_hit;

      assign acc_sel = acc_we && (acc_core == core_id_t'(i));
      assign exp_sel = exp_ent && (exp_core == core_id_t'(i));

      assign psr_hit  = acc_sel && (acc_addr == MSR_PSR);
      assign epsr_hit = acc_sel && (acc_addr == MSR_EPSR);
      assign epc_hit  = acc_sel && (acc_addr == MSR_EPC);
      assign elsa_hit = acc_sel && (acc_addr == MSR_ELSA);

      // A PSR write loads all five fields at once
      assign wr[i].cc_we    = psr_hit;
      assign wr[i].cc_nxt   = acc_wdata[PSR_CC];
      assign wr[i].rm_we    = psr_hit;
      assign wr[i].rm_nxt   = acc_wdata[PSR_RM];
      assign wr[i].ire_we   = psr_hit;
      assign wr[i].ire_nxt  = acc_wdata[PSR_IRE];
      assign wr[i].imme_we  = psr_hit;
      assign wr[i].imme_nxt = acc_wdata[PSR_IMME];
      assign wr[i].dmme_we  = psr_hit;
      assign wr[i].dmme_nxt = acc_wdata[PSR_DMME];

      // Mode bits are forced inside the bank
      assign wr[i].exp_ld = exp_sel;

      // Exception entry wins over an access write to the same register
      assign wr[i].epsr_we  = epsr_hit || exp_sel;
      assign wr[i].epsr_nxt = exp_sel ? rd[i].psr_nold : acc_wdata[PSR_W-1:0];
      assign wr[i].epc_we   = epc_hit || exp_sel;
      assign wr[i].epc_nxt  = exp_sel ? exp_epc : acc_wdata;
      assign wr[i].elsa_we  = elsa_hit || exp_sel;
      assign wr[i].elsa_nxt = exp_sel ? exp_elsa : acc_wdata;
   end

endmodule

`default_nettype wire

// File: msr_bank/msr_bank.sv
// Status registers of one core, with field loads, exception update and write bypass
`timescale 1ns/1ps
`default_nettype none

module msr_bank (
   input  logic                clk,
   input  logic                rst,
   input  core_pkg::core_id_t  core_index,
   msr_wr_if.bank              wr,
   msr_rd_if.bank              rd
);
   import msr_pkg::*;
   import core_pkg::*;

   function automatic psr_t pack_psr(input logic cc, input logic rm, input logic ire,
                                     input logic imme, input logic dmme);
      psr_t p;
      p           = '0;
      p[PSR_CC]   = cc;
      p[PSR_RM]   = rm;
      p[PSR_IRE]  = ire;
      p[PSR_IMME] = imme;
      p[PSR_DMME] = dmme;
      return p;
   endfunction

   logic  cc_r;
   logic  rm_r;
   logic  ire_r;
   logic  imme_r;
   logic  dmme_r;
   psr_t  epsr_r;
   word_t epc_r;
   word_t elsa_r;

   // Load enables and values of the mode fields including the exception load
   logic  rm_ld;
   logic  ire_ld;
   logic  imme_ld;
   logic  dmme_ld;
   logic  rm_val;
   logic  ire_val;
   logic  imme_val;
   logic  dmme_val;

   assign rm_ld   = wr.rm_we   || wr.exp_ld;
   assign ire_ld  = wr.ire_we  || wr.exp_ld;
   assign imme_ld = wr.imme_we || wr.exp_ld;
   assign dmme_ld = wr.dmme_we || wr.exp_ld;

   // Exception entry sets root mode and turns off interrupts and both MMUs
   assign rm_val   = wr.rm_nxt   || wr.exp_ld;
   assign ire_val  = wr.ire_nxt  && !wr.exp_ld;
   assign imme_val = wr.imme_nxt && !wr.exp_ld;
   assign dmme_val = wr.dmme_nxt && !wr.exp_ld;

   always_ff @(posedge clk) begin
      if (rst) begin
         cc_r   <= PSR_RESET[PSR_CC];
         rm_r   <= PSR_RESET[PSR_RM];
         ire_r  <= PSR_RESET[PSR_IRE];
         imme_r <= PSR_RESET[PSR_IMME];
         dmme_r <= PSR_RESET[PSR_DMME];
         epsr_r <= '0;
         epc_r  <= '0;
         elsa_r <= '0;
      end else begin
         if (wr.cc_we) cc_r <= wr.cc_nxt;
         if (rm_ld) rm_r <= rm_val;
         if (ire_ld) ire_r <= ire_val;
         if (imme_ld) imme_r <= imme_val;
         if (dmme_ld) dmme_r <= dmme_val;
         if (wr.epsr_we) epsr_r <= wr.epsr_nxt;
         if (wr.epc_we) epc_r <= wr.epc_nxt;
         if (wr.elsa_we) elsa_r <= wr.elsa_nxt;
      end
   end

   // Bypass of this cycle's writes
   logic cc_byp;
   assign cc_byp = wr.cc_we ? wr.cc_nxt : cc_r;

   assign rd.psr = pack_psr(cc_byp,
                            rm_ld   ? rm_val   : rm_r,
                            ire_ld  ? ire_val  : ire_r,
                            imme_ld ? imme_val : imme_r,
                            dmme_ld ? dmme_val : dmme_r);

   // Same bypass minus the exception load, so EPSR sees the pre-exception state
   assign rd.psr_nold = pack_psr(cc_byp,
                                 wr.rm_we   ? wr.rm_nxt   : rm_r,
                                 wr.ire_we  ? wr.ire_nxt  : ire_r,
                                 wr.imme_we ? wr.imme_nxt : imme_r,
                                 wr.dmme_we ? wr.dmme_nxt : dmme_r);

   assign rd.epsr = wr.epsr_we ? wr.epsr_nxt : epsr_r;
   assign rd.epc  = wr.epc_we  ? wr.epc_nxt  : epc_r;
   assign rd.elsa = wr.elsa_we ? wr.elsa_nxt : elsa_r;

   // Read-only identification
   assign rd.cpuid  = CPUID_WORD;
   assign rd.coreid = word_t'(core_index);

endmodule

`default_nettype wire

// File: hdl/msr_read_mux.sv
// Selects the MSR read word by core and address and exports every core's PSR
`timescale 1ns/1ps
`default_nettype none

module msr_read_mux (
   input  core_pkg::core_id_t  acc_core,
   input  msr_pkg::msr_addr_t  acc_addr,
   msr_rd_if.reader            rd [core_pkg::NUM_CORES],
   output msr_pkg::word_t      acc_rdata,
   output msr_pkg::psr_t       core_psr [core_pkg::NUM_CORES]
);
   import msr_pkg::*;
   import core_pkg::*;

   // Flat copies of the bank outputs, indexed by acc_core
   psr_t  psr_a    [NUM_CORES];
   psr_t  epsr_a   [NUM_CORES];
   word_t epc_a    [NUM_CORES];
   word_t elsa_a   [NUM_CORES];
   word_t cpuid_a  [NUM_CORES];
   word_t coreid_a [NUM_CORES];

   for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
      assign psr_a[i]    = rd[i].psr;
      assign epsr_a[i]   = rd[i].epsr;
      assign epc_a[i]    = rd[i].epc;
      assign elsa_a[i]   = rd[i].elsa;
      assign cpuid_a[i]  = rd[i].cpuid;
      assign coreid_a[i] = rd[i].coreid;

      assign core_psr[i] = rd[i].psr;
   end

   always_comb begin
      case (acc_addr)
         MSR_PSR:    acc_rdata = word_t'(psr_a[acc_core]);
         MSR_CPUID:  acc_rdata = cpuid_a[acc_core];
         MSR_EPSR:   acc_rdata = word_t'(epsr_a[acc_core]);
         MSR_EPC:    acc_rdata = epc_a[acc_core];
         MSR_ELSA:   acc_rdata = elsa_a[acc_core];
         MSR_COREID: acc_rdata = coreid_a[acc_core];
         // Unused codes
         default:    acc_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/msr_cluster.sv
// Top level of the cluster MSR block: decoder, one register bank per core and read mux
`timescale 1ns/1ps
`default_nettype none

module msr_cluster (
   input  logic                clk,
   input  logic                rst,
   // Shared access port
   input  core_pkg::core_id_t  acc_core,
   input  msr_pkg::msr_addr_t  acc_addr,
   input  logic                acc_we,
   input  msr_pkg::word_t      acc_wdata,
   output msr_pkg::word_t      acc_rdata,
   // Exception entry
   input  logic                exp_ent,
   input  core_pkg::core_id_t  exp_core,
   input  msr_pkg::word_t      exp_epc,
   input  msr_pkg::word_t      exp_elsa,
   output msr_pkg::psr_t       core_psr [core_pkg::NUM_CORES]
);
   import core_pkg::*;

   msr_wr_if wr_bus [NUM_CORES] ();
   msr_rd_if rd_bus [NUM_CORES] ();

   msr_access_decoder u_decoder (
      .acc_core  (acc_core),
      .acc_addr  (acc_addr),
      .acc_we    (acc_we),
      .acc_wdata (acc_wdata),
      .exp_ent   (exp_ent),
      .exp_core  (exp_core),
      .exp_epc   (exp_epc),
      .exp_elsa  (exp_elsa),
      .wr        (wr_bus),
      .rd        (rd_bus)
   );

   for (genvar i = 0; i < NUM_CORES; i++) begin : g_bank
      msr_bank u_bank (
         .clk        (clk),
         .rst        (rst),
         .core_index (core_id_t'(i)),
         .wr         (wr_bus[i]),
         .rd         (rd_bus[i])
      );
   end

   msr_read_mux u_read_mux (
      .acc_core  (acc_core),
      .acc_addr  (acc_addr),
      .rd        (rd_bus),
      .acc_rdata (acc_rdata),
      .core_psr  (core_psr)
   );

endmodule

`default_nettype wire

// File: testbench/tb_msr_cluster.sv
// Self-checking testbench for the cluster MSR block, run as the simulation top with the file list
`timescale 1ns/1ps
`default_nettype none

module tb_msr_cluster;
   import msr_pkg::*;
   import core_pkg::*;

   localparam int CLK_PERIOD      = 8;
   localparam int RESET_CYCLES    = 5;
   localparam int DIRECTED_CYCLES = 90;
   localparam int RANDOM_CYCLES   = 400;
   localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
   localparam logic [31:0] LFSR_SEED = 32'he6a1;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
   // Version 1, revision 0, flags imm, dmm, irqc and tsc
   localparam word_t EXP_CPUID = 32'h030C_0001;

   logic      clk;
   logic      rst;
   core_id_t  acc_core;
   msr_addr_t acc_addr;
   logic      acc_we;
   word_t     acc_wdata;
   word_t     acc_rdata;
   logic      exp_ent;
   core_id_t  exp_core;
   word_t     exp_epc;
   word_t     exp_elsa;
   psr_t      core_psr [NUM_CORES];

   // Shadow model of the registered state
   logic  m_cc   [NUM_CORES];
   logic  m_rm   [NUM_CORES];
   logic  m_ire  [NUM_CORES];
   logic  m_imme [NUM_CORES];
   logic  m_dmme [NUM_CORES];
   psr_t  m_epsr [NUM_CORES];
   word_t m_epc  [NUM_CORES];
   word_t m_elsa [NUM_CORES];

   logic [31:0] lfsr_state;

   msr_cluster DUT (
      .clk       (clk),
      .rst       (rst),
      .acc_core  (acc_core),
      .acc_addr  (acc_addr),
      .acc_we    (acc_we),
      .acc_wdata (acc_wdata),
      .acc_rdata (acc_rdata),
      .exp_ent   (exp_ent),
      .exp_core  (exp_core),
      .exp_epc   (exp_epc),
      .exp_elsa  (exp_elsa),
      .core_psr  (core_psr)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic psr_t psr_from_fields(input logic cc, input logic rm, input logic ire,
                                            input logic imme, input logic dmme);
      return {2'b00, dmme, imme, ire, rm, 3'b000, cc};
   endfunction

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? LFSR_TAPS : 32'd0);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   task automatic stop_with_failure;
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic reset_model;
      for (int c = 0; c < NUM_CORES; c++) begin
         m_cc[c]   = 1'b0;
         m_rm[c]   = 1'b1;
         m_ire[c]  = 1'b0;
         m_imme[c] = 1'b0;
         m_dmme[c] = 1'b0;
         m_epsr[c] = '0;
         m_epc[c]  = '0;
         m_elsa[c] = '0;
      end
   endtask

   // Compare against the expected bypassed outputs and commit as the edge would
   task automatic check_cycle;
      logic  n_cc   [NUM_CORES];
      logic  n_rm   [NUM_CORES];
      logic  n_ire  [NUM_CORES];
      logic  n_imme [NUM_CORES];
      logic  n_dmme [NUM_CORES];
      psr_t  n_epsr [NUM_CORES];
      word_t n_epc  [NUM_CORES];
      word_t n_elsa [NUM_CORES];
      psr_t  exp_psr [NUM_CORES];
      psr_t  pre_psr;
      word_t exp_rdata;
      logic  hit;
      logic  ex;
      for (int c = 0; c < NUM_CORES; c++) begin
         hit = acc_we && (acc_core == core_id_t'(c));
         ex  = exp_ent && (exp_core == core_id_t'(c));
         n_cc[c]   = m_cc[c];
         n_rm[c]   = m_rm[c];
         n_ire[c]  = m_ire[c];
         n_imme[c] = m_imme[c];
         n_dmme[c] = m_dmme[c];
         n_epsr[c] = m_epsr[c];
         n_epc[c]  = m_epc[c];
         n_elsa[c] = m_elsa[c];
         if (hit && acc_addr == MSR_PSR) begin
            n_cc[c]   = acc_wdata[0];
            n_rm[c]   = acc_wdata[4];
            n_ire[c]  = acc_wdata[5];
            n_imme[c] = acc_wdata[6];
            n_dmme[c] = acc_wdata[7];
         end
         if (hit && acc_addr == MSR_EPSR) n_epsr[c] = acc_wdata[9:0];
         if (hit && acc_addr == MSR_EPC) n_epc[c] = acc_wdata;
         if (hit && acc_addr == MSR_ELSA) n_elsa[c] = acc_wdata;
         pre_psr = psr_from_fields(n_cc[c], n_rm[c], n_ire[c], n_imme[c], n_dmme[c]);
         // Exception entry overrides everything but cc
         if (ex) begin
            n_rm[c]   = 1'b1;
            n_ire[c]  = 1'b0;
            n_imme[c] = 1'b0;
            n_dmme[c] = 1'b0;
            n_epsr[c] = pre_psr;
            n_epc[c]  = exp_epc;
            n_elsa[c] = exp_elsa;
         end
         exp_psr[c] = psr_from_fields(n_cc[c], n_rm[c], n_ire[c], n_imme[c], n_dmme[c]);
      end
      case (acc_addr)
         MSR_PSR:    exp_rdata = {22'd0, exp_psr[acc_core]};
         MSR_CPUID:  exp_rdata = EXP_CPUID;
         MSR_EPSR:   exp_rdata = {22'd0, n_epsr[acc_core]};
         MSR_EPC:    exp_rdata = n_epc[acc_core];
         MSR_ELSA:   exp_rdata = n_elsa[acc_core];
         MSR_COREID: exp_rdata = {30'd0, acc_core};
         default:    exp_rdata = '0;
      endcase
      assert (acc_rdata === exp_rdata) else begin
         $display("CHECK FAILED at %0t: acc_rdata core %0d addr %0d is %h, expected %h",
                  $time, acc_core, acc_addr, acc_rdata, exp_rdata);
         stop_with_failure();
      end
      for (int c = 0; c < NUM_CORES; c++) begin
         assert (core_psr[c] === exp_psr[c]) else begin
            $display("CHECK FAILED at %0t: core_psr[%0d] is %h, expected %h",
                     $time, c, core_psr[c], exp_psr[c]);
            stop_with_failure();
         end
         m_cc[c]   = n_cc[c];
         m_rm[c]   = n_rm[c];
         m_ire[c]  = n_ire[c];
         m_imme[c] = n_imme[c];
         m_dmme[c] = n_dmme[c];
         m_epsr[c] = n_epsr[c];
         m_epc[c]  = n_epc[c];
         m_elsa[c] = n_elsa[c];
      end
   endtask

   task automatic drive_cycle(input logic we, input core_id_t core, input msr_addr_t addr,
                              input word_t wdata, input logic ee, input core_id_t ecore,
                              input word_t epc, input word_t elsa);
      @(posedge clk);
      #1;
      acc_we    = we;
      acc_core  = core;
      acc_addr  = addr;
      acc_wdata = wdata;
      exp_ent   = ee;
      exp_core  = ecore;
      exp_epc   = epc;
      exp_elsa  = elsa;
      // Sample 1 ns before the next edge
      #(CLK_PERIOD - 2);
      check_cycle();
   endtask

   task automatic read_reg(input core_id_t core, input msr_addr_t addr);
      drive_cycle(1'b0, core, addr, '0, 1'b0, 2'd0, '0, '0);
   endtask

   task automatic write_reg(input core_id_t core, input msr_addr_t addr, input word_t data);
      drive_cycle(1'b1, core, addr, data, 1'b0, 2'd0, '0, '0);
   endtask

   task automatic run_random_phase;
      logic     we;
      core_id_t core;
      msr_addr_t addr;
      word_t    wdata;
      logic     ee;
      core_id_t ecore;
      word_t    epc;
      word_t    elsa;
      for (int n = 0; n < RANDOM_CYCLES; n++) begin
         we    = take_bits(1) == 32'd1;
         core  = core_id_t'(take_bits(2));
         addr  = msr_addr_t'(3'(take_bits(3)));
         wdata = take_bits(32);
         // Exception entry in about one cycle out of four
         ee    = take_bits(2) == 32'd0;
         ecore = core_id_t'(take_bits(2));
         epc   = take_bits(32);
         elsa  = take_bits(32);
         drive_cycle(we, core, addr, wdata, ee, ecore, epc, elsa);
      end
   endtask

   initial begin
      #((TOTAL_CYCLES + 20) * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d cycles", TOTAL_CYCLES + 20);
      stop_with_failure();
   end

   initial begin
      lfsr_state = LFSR_SEED;
      clk       = 1'b0;
      rst       = 1'b1;
      acc_core  = 2'd0;
      acc_addr  = MSR_PSR;
      acc_we    = 1'b0;
      acc_wdata = '0;
      exp_ent   = 1'b0;
      exp_core  = 2'd0;
      exp_epc   = '0;
      exp_elsa  = '0;
      reset_model();
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;

      // Reset values and unused codes
      for (int c = 0; c < NUM_CORES; c++) begin
         read_reg(core_id_t'(c), MSR_PSR);
         read_reg(core_id_t'(c), MSR_EPSR);
         read_reg(core_id_t'(c), MSR_EPC);
         read_reg(core_id_t'(c), MSR_ELSA);
         read_reg(core_id_t'(c), msr_addr_t'(3'd6));
         read_reg(core_id_t'(c), msr_addr_t'(3'd7));
      end

      // Read-only identification words
      for (int c = 0; c < NUM_CORES; c++) begin
         read_reg(core_id_t'(c), MSR_CPUID);
         read_reg(core_id_t'(c), MSR_COREID);
         write_reg(core_id_t'(c), MSR_CPUID, 32'hFFFF_FFFF);
         write_reg(core_id_t'(c), MSR_COREID, 32'hFFFF_FFFF);
         read_reg(core_id_t'(c), MSR_CPUID);
         read_reg(core_id_t'(c), MSR_COREID);
      end

      // Plain writes to one core
      write_reg(2'd2, MSR_PSR, 32'hFFFF_FFFF);
      read_reg(2'd2, MSR_PSR);
      write_reg(2'd2, MSR_EPC, 32'h1234_5678);
      write_reg(2'd2, MSR_ELSA, 32'h9ABC_DEF0);
      write_reg(2'd2, MSR_EPSR, 32'hFFFF_FFFF);
      read_reg(2'd2, MSR_EPSR);
      read_reg(2'd2, MSR_EPC);
      read_reg(2'd2, MSR_ELSA);
      read_reg(2'd1, MSR_PSR);
      read_reg(2'd3, MSR_EPC);
      write_reg(2'd2, MSR_PSR, 32'h0000_0000);

      // Exception entry on core 1 with cc and all enables set
      write_reg(2'd1, MSR_PSR, 32'h0000_00E1);
      drive_cycle(1'b0, 2'd1, MSR_PSR, '0, 1'b1, 2'd1, 32'h8000_0100, 32'hDEAD_BEE0);
      read_reg(2'd1, MSR_EPSR);
      read_reg(2'd1, MSR_EPC);
      read_reg(2'd1, MSR_ELSA);

      // Exception against a same-cycle write to the same core
      drive_cycle(1'b1, 2'd3, MSR_PSR, 32'h0000_00E1, 1'b1, 2'd3, 32'h0000_0400, 32'h0000_0800);
      read_reg(2'd3, MSR_PSR);
      drive_cycle(1'b1, 2'd3, MSR_EPC, 32'h5555_5555, 1'b1, 2'd3, 32'h0000_0440, 32'h0000_0880);
      read_reg(2'd3, MSR_EPC);
      drive_cycle(1'b1, 2'd3, MSR_EPSR, 32'h0000_03FF, 1'b1, 2'd3, 32'h0000_0480, 32'h0000_08C0);
      read_reg(2'd3, MSR_EPSR);
      // Write to another core in the same cycle
      drive_cycle(1'b1, 2'd0, MSR_PSR, 32'h0000_00F1, 1'b1, 2'd3, 32'h0000_0500, 32'h0000_0900);
      read_reg(2'd0, MSR_PSR);
      read_reg(2'd3, MSR_ELSA);

      run_random_phase();

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
common/msr_pkg.sv
common/core_pkg.sv
common/msr_wr_if.sv
common/msr_rd_if.sv
hdl/msr_access_decoder.sv
msr_bank/msr_bank.sv
hdl/msr_read_mux.sv
hdl/msr_cluster.sv
testbench/tb_msr_cluster.sv

// File: run_sim.sh
#!/bin/sh
# Builds the MSR cluster testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
   --top-module tb_msr_cluster \
   -f build.f \
   -o tb_msr_cluster

./obj_dir/tb_msr_cluster
